/* loader_stimulus.txt */
# Records: open <index> <homebrew>, beat <addr> <data>, fill <count>, close, expect <output> <value>
# Numbers are hex, several records may share a line
open 45 0 expect cart_download 1 beat 0 1234 fill 6 beat 3e 5a5a close
expect cart_loaded 1 expect cart_type 1 expect last_addr 3e expect cart_download 0
open 81 0 fill 4 beat 100 4c46 beat 102 5341 beat 104 3148 beat 106 5f4d beat 108 0056
fill 3 close expect flash_1m 1 expect cart_type 2
open 45 0 fill 8 close expect flash_1m 0
open 45 0 beat 100 4600 beat 102 414c beat 104 4853 beat 106 4d31 beat 108 565f close
expect flash_1m 1
open 45 0 beat a0 4143 beat a2 5453 beat a4 454c beat a6 4156 beat a8 494e beat aa 0041
beat ac 0000 close expect sram_quirk 1 expect memory_remap_quirk 1
open 45 0 expect sram_quirk 0 expect memory_remap_quirk 0 close
open 45 0 beat a0 4f52 beat a2 4b43 beat a4 2059 beat a6 4f42 beat a8 4958 beat aa 474e
beat ac 0000 close expect sram_quirk 1 expect memory_remap_quirk 0
open 0 0 beat 0 5678 beat 2 1234 close expect bios_writes 1 expect bios_wraddr 0
expect bios_wrdata 12345678 open 0 1 beat 4 aaaa beat 6 bbbb close expect bios_writes 1
open ff 0 beat 0 0001 beat 2 0000 beat 4 1234 beat 6 0300 beat 8 beef beat a dead
beat c cafe beat e 0bad close expect cheat_clears 1 expect cheat_valids 1
expect cheat_code 0000000103001234deadbeef0badcafe

/* project.f */
loader_pkg.sv
cart_pkg.sv
ioctl_if.sv
download_router.sv
cart_inspector.sv
bios_word_packer.sv
cheat_code_packer.sv
gba_loader_top.sv
gba_loader_properties.sv
tb_gba_loader.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_gba_loader
FILELIST  := project.f
PASS_MSG  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* tb_gba_loader.sv */
// Loader testbench

`timescale 1ns/1ps

module tb_gba_loader import loader_pkg::*; ();

	localparam int CLK_PERIOD = 100;     // ns
	localparam int LCG_SEED   = 66198;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout;
	logic                    ioctl_wr;
	logic                    homebrew_bios;
	logic                    cart_download;
	logic                    cart_loaded;
	cart_type_t              cart_type;
	logic [IOCTL_ADDR_W-1:0] last_addr;
	logic                    flash_1m;
	logic                    sram_quirk;
	logic                    memory_remap_quirk;
	logic [11:0]             bios_wraddr;
	logic [31:0]             bios_wrdata;
	logic                    bios_wr;
	cheat_code_t             cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;

	string                   tokens[$];               // Stimulus words without comments
	int                      tok_pos      = 0;
	int                      rec_count    = 0;
	logic                    loaded       = 1'b0;     // Stimulus file read in
	dl_kind_t                tb_kind      = DL_NONE;  // Kind of the open download
	logic [IOCTL_ADDR_W-1:0] next_addr    = '0;       // Filler carries on here
	int                      lcg_state    = LCG_SEED;
	int                      bios_writes  = 0;
	int                      cheat_valids = 0;
	int                      cheat_clears = 0;
	logic                    bios_exp     = 1'b0;     // Strobes due this cycle
	logic                    valid_exp    = 1'b0;

	gba_loader_top #(.BIOS_ADDR_W(12)) uut (.*);

	always #(CLK_PERIOD/2) clk_sys = ~clk_sys;

	// ==============================
	// Helpers
	// ==============================
	task automatic report_and_stop(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic bit_ok(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_and_stop($sformatf("FAILED t=%0t %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic cart_type_ok(input string name, input cart_type_t got,
			input cart_type_t exp);
		if (got !== exp)
			report_and_stop($sformatf("FAILED t=%0t %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic addr_ok(input string name, input logic [IOCTL_ADDR_W-1:0] got,
			input logic [IOCTL_ADDR_W-1:0] exp);
		if (got !== exp)
			report_and_stop($sformatf("FAILED t=%0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic word_ok(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_and_stop($sformatf("FAILED t=%0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic cheat_code_ok(input string name, input cheat_code_t got,
			input cheat_code_t exp);
		if (got !== exp)
			report_and_stop($sformatf("FAILED t=%0t %s got %h expected %h",
				$time, name, got, exp));
	endtask

	function automatic int lcg_next(input int state);
		return state * 1103515245 + 12345;
	endfunction

	// Filler must never spell part of the flash signature
	function automatic logic [15:0] replace_f_bytes(input logic [15:0] data);
		logic [15:0] res;
		res = data;
		if (res[7:0] == 8'h46)
			res[7:0] = 8'h47;
		if (res[15:8] == 8'h46)
			res[15:8] = 8'h47;
		return res;
	endfunction

	function automatic string next_token();
		string tok;
		tok = (tok_pos < tokens.size()) ? tokens[tok_pos] : "";
		tok_pos++;
		return tok;
	endfunction

	function automatic logic [127:0] hex_value(input string tok);
		logic [127:0] v;
		v = '0;
		if ($sscanf(tok, "%h", v) != 1)
			v = '0;
		return v;
	endfunction

	// ==============================
	// Stream driving
	// ==============================
	task automatic open_download(input logic [7:0] index, input logic homebrew);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		homebrew_bios  <= homebrew;
		tb_kind        <= (index == IDX_BIOS)  ? DL_BIOS :
		                  (index == IDX_CHEAT) ? DL_CHEAT : DL_CART;
		next_addr = '0;
		repeat (3) @(posedge clk_sys);   // First beat well after the rise
	endtask

	task automatic drive_beat(input logic [IOCTL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;   // One cycle strobe
		next_addr = addr + 27'd2;
	endtask

	task automatic close_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		tb_kind        <= DL_NONE;
	endtask

	task automatic apply_expect(input string name, input logic [127:0] value);
		repeat (2) @(posedge clk_sys);   // Let status settle
		@(negedge clk_sys);
		case (name)
			"cart_download":      bit_ok(name, cart_download, value[0]);
			"cart_loaded":        bit_ok(name, cart_loaded, value[0]);
			"cart_type":          cart_type_ok(name, cart_type, value[1:0]);
			"last_addr":          addr_ok(name, last_addr, value[IOCTL_ADDR_W-1:0]);
			"flash_1m":           bit_ok(name, flash_1m, value[0]);
			"sram_quirk":         bit_ok(name, sram_quirk, value[0]);
			"memory_remap_quirk": bit_ok(name, memory_remap_quirk, value[0]);
			"bios_wraddr":        word_ok(name, 32'(bios_wraddr), value[31:0]);
			"bios_wrdata":        word_ok(name, bios_wrdata, value[31:0]);
			"bios_writes":        word_ok(name, 32'(bios_writes), value[31:0]);
			"cheat_valids":       word_ok(name, 32'(cheat_valids), value[31:0]);
			"cheat_clears":       word_ok(name, 32'(cheat_clears), value[31:0]);
			"cheat_code":         cheat_code_ok(name, cheat_code, value);
			default:              report_and_stop({"Unknown output in stimulus: ", name});
		endcase
	endtask

	// Strobes expected one cycle after the beat that owns them
	always @(posedge clk_sys) begin
		bios_exp  <= ioctl_wr && (tb_kind == DL_BIOS) && ioctl_addr[1] && !homebrew_bios;
		valid_exp <= ioctl_wr && (tb_kind == DL_CHEAT) && (ioctl_addr[3:0] == 4'd14);
	end

	always @(negedge clk_sys) begin
		if (!reset) begin
			bit_ok("bios_wr", bios_wr, bios_exp);
			bit_ok("cheat_valid", cheat_valid, valid_exp);
			if (uut.u_props.fail_count != 0)
				report_and_stop("An assertion in the loader checker failed");
			if (bios_wr)
				bios_writes++;
			if (cheat_valid)
				cheat_valids++;
			if (cheat_clear)
				cheat_clears++;
		end
	end

	// Watchdog allows 20 cycles per record plus reset
	initial begin
		wait (loaded);
		#((rec_count * 20 + 10) * CLK_PERIOD);
		report_and_stop("Watchdog expired before the stimulus was finished");
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int           fd;
		string        tok;
		string        op;
		string        name;
		logic [127:0] a;
		logic [127:0] b;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		homebrew_bios  = 1'b0;
		fd = $fopen("loader_stimulus.txt", "r");
		if (fd == 0)
			report_and_stop("Cannot open loader_stimulus.txt");
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok[0] == "#") begin
				void'($fgets(tok, fd));   // Rest of the comment line
			end else begin
				tokens.push_back(tok);
				if (tok == "open" || tok == "beat" || tok == "fill" ||
						tok == "close" || tok == "expect")
					rec_count++;
			end
		end
		$fclose(fd);
		loaded = 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		while (tok_pos < tokens.size()) begin
			op = next_token();
			case (op)
				"open": begin
					a = hex_value(next_token());   // Index
					b = hex_value(next_token());   // Homebrew BIOS switch
					open_download(a[7:0], b[0]);
				end
				"beat": begin
					a = hex_value(next_token());
					b = hex_value(next_token());
					drive_beat(a[IOCTL_ADDR_W-1:0], b[15:0]);
				end
				"fill": begin
					a = hex_value(next_token());
					repeat (a[15:0]) begin
						lcg_state = lcg_next(lcg_state);
						drive_beat(next_addr, replace_f_bytes(lcg_state[23:8]));
					end
				end
				"close":  close_download();
				"expect": begin
					name = next_token();
					a = hex_value(next_token());
					apply_expect(name, a);
				end
				default: report_and_stop({"Unknown stimulus record: ", op});
			endcase
		end
		repeat (2) @(posedge clk_sys);
		if (uut.u_props.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

/* gba_loader_properties.sv */
// Loader protocol assertions

`timescale 1ns/1ps

module gba_loader_properties import loader_pkg::*; (
	input logic       clk_sys,
	input logic       reset,
	input dl_kind_t   dl_kind,
	input logic       cart_start,
	input logic       bios_wr,
	input logic       cheat_valid,
	input logic       cheat_clear,
	input logic       cart_loaded,
	input cart_type_t cart_type,
	input logic       flash_1m,
	input logic       sram_quirk,
	input logic       memory_remap_quirk
);

	int unsigned fail_count = 0;   // Assertion failures so far
	logic [5:0]  flags;            // Every cart status output

	assign flags = {cart_loaded, cart_type, flash_1m, sram_quirk, memory_remap_quirk};

	// ==============================
	// Strobes last one cycle
	// ==============================
	bios_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr)
		else begin
			fail_count++;
			$error("bios_wr held longer than one cycle");
		end

	cheat_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
		else begin
			fail_count++;
			$error("cheat_valid held longer than one cycle");
		end

	cheat_clear_single: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_clear |=> !cheat_clear)
		else begin
			fail_count++;
			$error("cheat_clear held longer than one cycle");
		end

	// Idle stream leaves the cart status alone
	flags_hold_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(dl_kind == DL_NONE) && !cart_start |=> $stable(flags))
		else begin
			fail_count++;
			$error("Cart flags changed while no download was active");
		end

endmodule

bind gba_loader_top gba_loader_properties u_props (
	.clk_sys, .reset, .dl_kind, .cart_start,
	.bios_wr, .cheat_valid, .cheat_clear,
	.cart_loaded, .cart_type, .flash_1m, .sram_quirk, .memory_remap_quirk
);

/* gba_loader_top.sv */
// Loader top level

`timescale 1ns/1ps

module gba_loader_top import loader_pkg::*; #(
	parameter int BIOS_ADDR_W = 12   // 16 KB BIOS in words
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host download stream
	input  logic                      ioctl_download,
	input  logic [7:0]                ioctl_index,
	input  logic [IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic                      ioctl_wr,
	input  logic                      homebrew_bios,
	// Cartridge status
	output logic                      cart_download,
	output logic                      cart_loaded,
	output cart_type_t                cart_type,
	output logic [IOCTL_ADDR_W-1:0]   last_addr,
	output logic                      flash_1m,
	output logic                      sram_quirk,
	output logic                      memory_remap_quirk,
	// BIOS store writes
	output logic [BIOS_ADDR_W-1:0]    bios_wraddr,
	output logic [2*IOCTL_DATA_W-1:0] bios_wrdata,
	output logic                      bios_wr,
	// Cheat engine feed
	output cheat_code_t               cheat_code,
	output logic                      cheat_valid,
	output logic                      cheat_clear
);

	dl_kind_t dl_kind;
	logic     cart_start;

	// ==============================
	// Stream bundle, host side
	// ==============================
	ioctl_if #(.ADDR_W(IOCTL_ADDR_W), .DATA_W(IOCTL_DATA_W)) ioctl ();

	assign ioctl.download = ioctl_download;
	assign ioctl.index    = ioctl_index;
	assign ioctl.addr     = ioctl_addr;
	assign ioctl.dout     = ioctl_dout;
	assign ioctl.wr       = ioctl_wr;

	assign cart_download = (dl_kind == DL_CART);   // Busy flag for the core

	download_router u_router (
		.clk_sys, .reset, .ioctl,
		.dl_kind, .cart_start, .last_addr
	);

	cart_inspector u_inspector (
		.clk_sys, .reset, .ioctl, .dl_kind, .cart_start,
		.cart_loaded, .cart_type, .flash_1m, .sram_quirk, .memory_remap_quirk
	);

	bios_word_packer #(.BIOS_ADDR_W(BIOS_ADDR_W)) u_bios (
		.clk_sys, .reset, .ioctl, .dl_kind, .homebrew_bios,
		.bios_wraddr, .bios_wrdata, .bios_wr
	);

	cheat_code_packer u_cheat (
		.clk_sys, .reset, .ioctl, .dl_kind,
		.cheat_code, .cheat_valid, .cheat_clear
	);

endmodule

/* cheat_code_packer.sv */
// Cheat code packer

`timescale 1ns/1ps

module cheat_code_packer import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	ioctl_if.sink       ioctl,
	input  dl_kind_t    dl_kind,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,   // Code complete
	output logic        cheat_clear    // Drop old codes
);

	logic cheat_beat;
	logic download_q;   // Raw download one cycle back

	assign cheat_beat = (dl_kind == DL_CHEAT) && ioctl.wr;

	// ==============================
	// Record assembly
	// ==============================
	// 16 byte record, four words, low half first
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_code  <= '0;
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
			download_q  <= 1'b0;
		end else begin
			download_q  <= ioctl.download;
			cheat_clear <= ioctl.download && !download_q && (ioctl.index == IDX_CHEAT);
			cheat_valid <= 1'b0;
			if (cheat_beat) begin
				case (ioctl.addr[3:0])
					4'd0:  cheat_code.flags[15:0]    <= ioctl.dout;
					4'd2:  cheat_code.flags[31:16]   <= ioctl.dout;
					4'd4:  cheat_code.address[15:0]  <= ioctl.dout;
					4'd6:  cheat_code.address[31:16] <= ioctl.dout;
					4'd8:  cheat_code.compare[15:0]  <= ioctl.dout;
					4'd10: cheat_code.compare[31:16] <= ioctl.dout;
					4'd12: cheat_code.replace[15:0]  <= ioctl.dout;
					4'd14: begin
						cheat_code.replace[31:16] <= ioctl.dout;
						cheat_valid               <= 1'b1;   // Last beat of record
					end
					default: ;   // Odd offsets never carry a beat
				endcase
			end
		end
	end

endmodule

/* bios_word_packer.sv */
// BIOS word packer

`timescale 1ns/1ps

module bios_word_packer import loader_pkg::*; #(
	parameter int BIOS_ADDR_W = 12   // Word address width of the BIOS store
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	ioctl_if.sink                     ioctl,
	input  dl_kind_t                  dl_kind,
	input  logic                      homebrew_bios,   // Keep the built in BIOS
	output logic [BIOS_ADDR_W-1:0]    bios_wraddr,
	output logic [2*IOCTL_DATA_W-1:0] bios_wrdata,
	output logic                      bios_wr          // One cycle write strobe
);

	logic                    bios_beat;
	logic [IOCTL_DATA_W-1:0] low_half;   // Waiting for its partner

	assign bios_beat = (dl_kind == DL_BIOS) && ioctl.wr && !homebrew_bios;

	// Low half parked until bit 1 beat comes
	always_ff @(posedge clk_sys) begin
		if (bios_beat && !ioctl.addr[1])
			low_half <= ioctl.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_wraddr <= '0;
			bios_wrdata <= '0;
			bios_wr     <= 1'b0;
		end else begin
			bios_wr <= 1'b0;
			if (bios_beat && ioctl.addr[1]) begin
				bios_wrdata <= {ioctl.dout, low_half};       // High half on top
				bios_wraddr <= ioctl.addr[BIOS_ADDR_W+1:2];   // Byte to word address
				bios_wr     <= 1'b1;
			end
		end
	end

endmodule

/* cart_inspector.sv */
// Cartridge image inspector

`timescale 1ns/1ps

module cart_inspector import loader_pkg::*, cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	ioctl_if.sink      ioctl,
	input  dl_kind_t   dl_kind,
	input  logic       cart_start,          // First cycle of a new cart
	output logic       cart_loaded,         // Sticky once any cart came in
	output cart_type_t cart_type,
	output logic       flash_1m,            // Signature seen in this image
	output logic       sram_quirk,          // Backup RAM must be off
	output logic       memory_remap_quirk
);

	logic        cart_beat;     // Valid beat of a cart file
	logic        header_beat;   // Beat inside the ID line
	logic [3:0]  offset;        // Byte offset within the line
	logic [15:0] beat_swap;     // Beat in file byte order
	logic [63:0] sig_hist;      // Last eight bytes, oldest on top
	logic        sig_even;      // Signature ends on the low byte
	logic        sig_odd;       // Signature ends on the high byte
	game_id_t    game_id;
	int          id_pos;        // Bit position of this beat in the ID
	logic        match_sram;
	logic        match_remap;

	assign cart_beat   = (dl_kind == DL_CART) && ioctl.wr;
	assign offset      = ioctl.addr[3:0];
	assign header_beat = cart_beat &&
		(ioctl.addr[IOCTL_ADDR_W-1:4] == (IOCTL_ADDR_W-4)'(HEADER_ID_LINE));
	assign beat_swap   = {ioctl.dout[7:0], ioctl.dout[15:8]};

	// ==============================
	// Flash signature search
	// ==============================
	// Nine chars never fit two beats evenly so test both alignments
	assign sig_even = ({sig_hist, ioctl.dout[7:0]} == FLASH_SIG);
	assign sig_odd  = ({sig_hist[55:0], beat_swap} == FLASH_SIG);

	// ==============================
	// Quirk lookup
	// ==============================
	always_comb begin
		id_pos      = (HEADER_ID_BYTES - 2 - int'(offset)) * 8;
		match_sram  = 1'b0;
		match_remap = 1'b0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (game_id == QUIRK_TABLE[i].id) begin
				match_sram  = QUIRK_TABLE[i].sram_off;
				match_remap = QUIRK_TABLE[i].remap;
			end
		end
	end

	// Byte history and header ID capture
	always_ff @(posedge clk_sys) begin
		if (cart_beat)
			sig_hist <= {sig_hist[47:0], beat_swap};
		if (header_beat && (offset < 4'(HEADER_ID_BYTES)))
			game_id[id_pos +: 16] <= beat_swap;   // Reading order
	end

	// Flags
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded        <= 1'b0;
			cart_type          <= '0;
			flash_1m           <= 1'b0;
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
		end else begin
			if (cart_start) begin
				cart_loaded        <= 1'b1;
				cart_type          <= ioctl.index[7:6];   // Index held for whole file
				flash_1m           <= 1'b0;
				sram_quirk         <= 1'b0;
				memory_remap_quirk <= 1'b0;
			end
			if (cart_beat && (sig_even || sig_odd))
				flash_1m <= 1'b1;
			// Whole ID is in once the beat after it shows up
			if (header_beat && (offset == 4'(HEADER_ID_BYTES))) begin
				sram_quirk         <= match_sram;
				memory_remap_quirk <= match_remap;
			end
		end
	end

endmodule

/* download_router.sv */
// Download kind router

`timescale 1ns/1ps

module download_router import loader_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	ioctl_if.sink                   ioctl,
	output dl_kind_t                dl_kind,      // Registered file kind
	output logic                    cart_start,   // One cycle after kind turns cart
	output logic [IOCTL_ADDR_W-1:0] last_addr     // Last cart beat address
);

	dl_kind_t                kind_next;    // Decoded from the raw stream
	dl_kind_t                prev_kind;    // Kind one cycle back
	logic [IOCTL_ADDR_W-1:0] beat_addr;    // Address of the latest cart beat

	// ==============================
	// Index decode
	// ==============================
	always_comb begin
		if (!ioctl.download)
			kind_next = DL_NONE;
		else if (ioctl.index == IDX_BIOS)
			kind_next = DL_BIOS;
		else if (ioctl.index == IDX_CHEAT)
			kind_next = DL_CHEAT;
		else
			kind_next = DL_CART;   // Every other index
	end

	// Kind register and edge detection
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind    <= DL_NONE;
			prev_kind  <= DL_NONE;
			cart_start <= 1'b0;
			last_addr  <= '0;
		end else begin
			dl_kind    <= kind_next;
			prev_kind  <= dl_kind;   // Edge reference
			cart_start <= (dl_kind == DL_CART) && (prev_kind != DL_CART);
			// Cart file just ended so keep its size
			if ((prev_kind == DL_CART) && (dl_kind != DL_CART))
				last_addr <= beat_addr;
		end
	end

	// Track each cart beat, the final one wins
	always_ff @(posedge clk_sys) begin
		if ((dl_kind == DL_CART) && ioctl.wr)
			beat_addr <= ioctl.addr;
	end

endmodule

/* ioctl_if.sv */
// Host download stream bundle

`timescale 1ns/1ps

interface ioctl_if #(
	parameter int ADDR_W = 27,   // Byte address width
	parameter int DATA_W = 16    // Beat width
) ();

	logic              download;   // High for a whole file
	logic [7:0]        index;      // File kind, stable during download
	logic [ADDR_W-1:0] addr;       // Byte address of the beat
	logic [DATA_W-1:0] dout;       // Beat data, low byte first in file
	logic              wr;         // One cycle beat strobe

	// Stream source side
	modport host (output download, output index, output addr, output dout, output wr);

	// Every loader unit only listens
	modport sink (input download, input index, input addr, input dout, input wr);

endinterface

/* cart_pkg.sv */
// Cartridge header constants

package cart_pkg;

	// ==============================
	// Save type detection
	// ==============================
	// Flash 128K carts carry this string somewhere in the image
	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";

	// ==============================
	// Header game ID
	// ==============================
	localparam int HEADER_ID_LINE  = 'hA;   // 16 byte line 0xA0..0xAF
	localparam int HEADER_ID_BYTES = 12;    // Title field length

	typedef logic [HEADER_ID_BYTES*8-1:0] game_id_t;   // First char on top

	// One quirk table row
	typedef struct packed {
		game_id_t id;
		logic     sram_off;   // Cart has no SRAM/flash backup
		logic     remap;      // NES classic style mirroring
	} cart_quirk_t;

	// ==============================
	// Quirk table
	// ==============================
	localparam int QUIRK_COUNT = 6;

	localparam cart_quirk_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{id: "ROCKY BOXING",                 sram_off: 1'b1, remap: 1'b0},
		'{id: {"IRIDIONII", 24'h000000},      sram_off: 1'b1, remap: 1'b0},
		'{id: "DBZ TAIKETSU",                 sram_off: 1'b1, remap: 1'b0},
		// Classic NES series below
		'{id: {"CASTLEVANIA", 8'h00},         sram_off: 1'b1, remap: 1'b1},
		'{id: "SUPER MARIO2",                 sram_off: 1'b1, remap: 1'b1},
		'{id: {"MAPPY", 56'h00000000000000},  sram_off: 1'b1, remap: 1'b1}
	};

endpackage

/* loader_pkg.sv */
// Loader stream definitions

package loader_pkg;

	// ==============================
	// Host download stream
	// ==============================
	localparam int IOCTL_ADDR_W = 27;   // Byte address width
	localparam int IOCTL_DATA_W = 16;   // One beat

	// Stream index codes
	localparam logic [7:0] IDX_BIOS  = 8'd0;     // Boot ROM image
	localparam logic [7:0] IDX_CHEAT = 8'd255;   // Cheat file
	// Any other index is a cartridge image

	// Kind of the file currently on the stream
	typedef enum logic [1:0] {
		DL_NONE,    // Stream idle
		DL_BIOS,
		DL_CART,
		DL_CHEAT
	} dl_kind_t;

	// Cart type sits in index bits 7:6
	typedef logic [1:0] cart_type_t;

	// One cheat code, big field first
	typedef struct packed {
		logic [31:0] flags;     // 127:96
		logic [31:0] address;   // 95:64
		logic [31:0] compare;   // 63:32
		logic [31:0] replace;   // 31:0
	} cheat_code_t;

endpackage
